// ==== hw/z80_dp_pkg.sv ====
package z80_dp_pkg;

  // --------------------
  // widths
  // --------------------

  // the datapath moves one byte at a time on the internal bus
  localparam int data_w = 8;
  // addresses are a full register pair wide
  localparam int addr_w = 16;

  typedef logic [data_w-1:0] byte_t;
  typedef logic [addr_w-1:0] word_t;

  // --------------------
  // selectors
  // --------------------

  // general registers in file order, so a pair is an even index and the one after it
  typedef enum logic [2:0] {
    REG_B = 3'd0,
    REG_C = 3'd1,
    REG_D = 3'd2,
    REG_E = 3'd3,
    REG_H = 3'd4,
    REG_L = 3'd5
  } reg_sel_t;

  // the pair code doubled gives the index of the high register
  typedef enum logic [1:0] {
    PAIR_BC = 2'd0,
    PAIR_DE = 2'd1,
    PAIR_HL = 2'd2
  } pair_sel_t;

  // exactly one of these owns the internal data bus in a cycle
  // DSRC_EXT takes the bus from the pins and keeps the output driver off
  typedef enum logic [2:0] {
    DSRC_EXT  = 3'd0,
    DSRC_REG  = 3'd1,
    DSRC_A    = 3'd2,
    DSRC_F    = 3'd3,
    DSRC_TEMP = 3'd4
  } data_src_t;

  typedef enum logic [2:0] {
    ALU_ADD    = 3'd0,
    ALU_ADC    = 3'd1,
    ALU_SUB    = 3'd2,
    ALU_SBC    = 3'd3,
    ALU_AND    = 3'd4,
    ALU_OR     = 3'd5,
    ALU_XOR    = 3'd6,
    ALU_PASS_B = 3'd7
  } alu_op_t;

  typedef enum logic [1:0] {
    CY_KEEP  = 2'd0,
    CY_SET   = 2'd1,
    CY_CLEAR = 2'd2
  } carry_cmd_t;

  typedef enum logic [1:0] {
    MAR_HOLD           = 2'd0,
    MAR_FROM_PAIR      = 2'd1,
    MAR_LOW_FROM_DATA  = 2'd2,
    MAR_HIGH_FROM_DATA = 2'd3
  } mar_ld_t;

  // --------------------
  // flag register
  // --------------------

  // Z80 layout of F, bit 7 down to bit 0
  // y and x are the undocumented copies of result bits 5 and 3, carried along untouched here
  typedef struct packed {
    logic s;
    logic z;
    logic y;
    logic h;
    logic x;
    logic pv;
    logic n;
    logic c;
  } flag_bits_t;

  // the bus sees F as one byte while the ALU and the carry override work on single bits
  typedef union packed {
    byte_t      word;
    flag_bits_t bits;
  } flags_t;

  // --------------------
  // control word
  // --------------------

  // one of these arrives every cycle from the control unit and acts at the next edge
  typedef struct packed {
    logic       ld_reg;
    reg_sel_t   ld_reg_sel;
    logic       ld_pair;
    pair_sel_t  pair_sel;
    data_src_t  data_src;
    reg_sel_t   rd_sel;
    logic       ld_a;
    logic       a_from_alu;
    logic       ld_f;
    carry_cmd_t carry_cmd;
    logic       ld_temp;
    logic       alu_b_temp;
    alu_op_t    alu_op;
    mar_ld_t    mar_ld;
    logic       addr_drive;
  } dp_ctrl_t;

endpackage

// ==== hw/z80_regfile.sv ====
`timescale 1ns/10ps

module z80_regfile import z80_dp_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  dp_ctrl_t ctrl,
  input  byte_t    dbus,
  input  word_t    mar_q,
  output byte_t    reg_byte,
  output word_t    reg_pair
);

  // B, C, D, E, H, L in index order 0 to 5
  byte_t gpr [6];

  // index of the high and low halves of the selected pair
  logic [2:0] pair_hi;
  logic [2:0] pair_lo;

  assign pair_hi = {ctrl.pair_sel, 1'b0};
  assign pair_lo = {ctrl.pair_sel, 1'b1};

  // --------------------
  // write side
  // --------------------

  // a byte load takes the data bus, a pair load takes the MAR
  // the high byte of the MAR lands in B, D or H
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < 6; i++) begin
        gpr[i] <= '0;
      end
    end else begin
      for (int i = 0; i < 6; i++) begin
        if (ctrl.ld_reg && (ctrl.ld_reg_sel == 3'(i))) begin
          gpr[i] <= dbus;
        end else if (ctrl.ld_pair && (pair_hi == 3'(i))) begin
          gpr[i] <= mar_q[15:8];
        end else if (ctrl.ld_pair && (pair_lo == 3'(i))) begin
          gpr[i] <= mar_q[7:0];
        end
      end
    end
  end

  // --------------------
  // read side
  // --------------------

  // both reads are live every cycle, the bus selector decides whether the byte is used
  // codes past REG_L read as zero rather than off the end of the array
  always_comb begin
    reg_byte = '0;
    if (ctrl.rd_sel <= REG_L) begin
      reg_byte = gpr[ctrl.rd_sel];
    end
  end

  // the fourth pair code has no registers behind it
  always_comb begin
    reg_pair = '0;
    if (ctrl.pair_sel != 2'd3) begin
      reg_pair = {gpr[pair_hi], gpr[pair_lo]};
    end
  end

  // the byte and pair loads share write ports on the same registers
  // the control unit must never ask for both in one cycle
  a_no_byte_and_pair_load: assert property (
    @(posedge clk) disable iff (!rst_n)
    !(ctrl.ld_reg && ctrl.ld_pair)
  );

endmodule

// ==== hw/z80_alu.sv ====
`timescale 1ns/10ps

module z80_alu import z80_dp_pkg::*; (
  input  alu_op_t op,
  input  byte_t   a,
  input  byte_t   b,
  input  flags_t  f_in,
  output byte_t   res,
  output flags_t  f_out
);

  // carry into bit 0, only ADC and SBC look at the old carry
  logic       cin;
  // nine bits so the carry or borrow out of bit 7 falls into the top bit
  logic [8:0] full;
  // five bits so the carry or borrow between nibbles falls into bit 4
  logic [4:0] half;

  assign cin = ((op == ALU_ADC) || (op == ALU_SBC)) ? f_in.bits.c : 1'b0;

  always_comb begin
    full  = '0;
    half  = '0;
    res   = b;
    // flags not named below keep their old value, which is all PASS_B does
    f_out = f_in;

    case (op)
      ALU_ADD, ALU_ADC: begin
        full = {1'b0, a} + {1'b0, b} + 9'(cin);
        half = {1'b0, a[3:0]} + {1'b0, b[3:0]} + 5'(cin);
        res  = full[7:0];
        f_out.bits.h  = half[4];
        f_out.bits.c  = full[8];
        // overflow when both operands share a sign and the result does not
        f_out.bits.pv = (a[7] == b[7]) && (res[7] != a[7]);
        f_out.bits.n  = 1'b0;
      end

      ALU_SUB, ALU_SBC: begin
        // a borrow wraps the unsigned difference and sets the extra top bit
        full = {1'b0, a} - {1'b0, b} - 9'(cin);
        half = {1'b0, a[3:0]} - {1'b0, b[3:0]} - 5'(cin);
        res  = full[7:0];
        f_out.bits.h  = half[4];
        f_out.bits.c  = full[8];
        // subtracting an operand of opposite sign can cross the sign boundary
        f_out.bits.pv = (a[7] != b[7]) && (res[7] != a[7]);
        f_out.bits.n  = 1'b1;
      end

      ALU_AND, ALU_OR, ALU_XOR: begin
        if (op == ALU_AND) begin
          res = a & b;
        end else if (op == ALU_OR) begin
          res = a | b;
        end else begin
          res = a ^ b;
        end
        // the Z80 sets h on AND only
        f_out.bits.h  = (op == ALU_AND);
        f_out.bits.c  = 1'b0;
        f_out.bits.n  = 1'b0;
        // pv reads as parity here, set when the count of ones is even
        f_out.bits.pv = ~^res;
      end

      default: begin
        res = b;
      end
    endcase

    // sign and zero follow the result for everything but PASS_B
    if (op != ALU_PASS_B) begin
      f_out.bits.s = res[7];
      f_out.bits.z = (res == '0);
    end
  end

  // A only becomes known once reset has cleared it, and from then on the
  // control unit must hand the ALU a real opcode every cycle
  always_comb begin
    if (!$isunknown(a)) begin
      a_op_known: assert (!$isunknown(op));
    end
  end

endmodule

// ==== hw/z80_acc_flags.sv ====
`timescale 1ns/10ps

module z80_acc_flags import z80_dp_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  dp_ctrl_t ctrl,
  input  byte_t    dbus,
  input  byte_t    alu_res,
  input  flags_t   alu_flags,
  output byte_t    acc,
  output flags_t   flags,
  output byte_t    temp
);

  // next value of F once the carry command has been laid over it
  flags_t f_next;
  logic   f_en;

  // --------------------
  // flag update
  // --------------------

  // start from the ALU flags on ld_f, otherwise from the current F
  // then the carry command has the last word on bit c only
  always_comb begin
    f_next = ctrl.ld_f ? alu_flags : flags;
    case (ctrl.carry_cmd)
      CY_SET:   f_next.bits.c = 1'b1;
      CY_CLEAR: f_next.bits.c = 1'b0;
      default:  f_next.bits.c = f_next.bits.c;
    endcase
  end

  // F is written either by an ALU flag load or by a carry command alone
  assign f_en = ctrl.ld_f || (ctrl.carry_cmd != CY_KEEP);

  // --------------------
  // storage
  // --------------------

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      acc   <= '0;
      flags <= '0;
      temp  <= '0;
    end else begin
      // the ALU result reaches A directly, the bus is busy with the operand then
      if (ctrl.ld_a) begin
        acc <= ctrl.a_from_alu ? alu_res : dbus;
      end
      if (f_en) begin
        flags <= f_next;
      end
      // TEMP latches a bus byte for use as the ALU operand in a later cycle
      if (ctrl.ld_temp) begin
        temp <= dbus;
      end
    end
  end

  // a_from_alu only steers the A input, so on its own it would silently do nothing
  a_alu_only_with_load: assert property (
    @(posedge clk) disable iff (!rst_n)
    ctrl.a_from_alu |-> ctrl.ld_a
  );

endmodule

// ==== hw/z80_bus_ctrl.sv ====
`timescale 1ns/10ps

module z80_bus_ctrl import z80_dp_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  dp_ctrl_t ctrl,
  input  byte_t    data_in,
  input  byte_t    reg_byte,
  input  byte_t    acc,
  input  flags_t   flags,
  input  byte_t    temp,
  input  word_t    reg_pair,
  output byte_t    dbus,
  output word_t    mar_q,
  output byte_t    data_out,
  output logic     data_oe,
  output word_t    addr_out,
  output logic     addr_oe
);

  // --------------------
  // data bus
  // --------------------

  // one named source per cycle, so a plain mux replaces the tri-state bus
  // the pins feed the bus whenever nothing inside is driving it
  always_comb begin
    dbus    = data_in;
    data_oe = 1'b0;
    case (ctrl.data_src)
      DSRC_REG: begin
        dbus    = reg_byte;
        data_oe = 1'b1;
      end
      DSRC_A: begin
        dbus    = acc;
        data_oe = 1'b1;
      end
      DSRC_F: begin
        // F goes out as a whole byte
        dbus    = flags.word;
        data_oe = 1'b1;
      end
      DSRC_TEMP: begin
        dbus    = temp;
        data_oe = 1'b1;
      end
      default: begin
        dbus    = data_in;
        data_oe = 1'b0;
      end
    endcase
  end

  // the outside sees the internal bus, and data_oe says whether to believe it
  assign data_out = dbus;

  // --------------------
  // memory address register
  // --------------------

  // a whole pair loads in one edge, a byte from the bus takes two edges, low then high
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mar_q <= '0;
    end else begin
      case (ctrl.mar_ld)
        MAR_FROM_PAIR:      mar_q <= reg_pair;
        MAR_LOW_FROM_DATA:  mar_q <= {mar_q[15:8], dbus};
        MAR_HIGH_FROM_DATA: mar_q <= {dbus, mar_q[7:0]};
        default:            mar_q <= mar_q;
      endcase
    end
  end

  // only the MAR can reach the address pins
  assign addr_out = mar_q;
  assign addr_oe  = ctrl.addr_drive;

endmodule

// ==== hw/z80_datapath.sv ====
`timescale 1ns/10ps

module z80_datapath import z80_dp_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  dp_ctrl_t ctrl,
  input  byte_t    data_in,
  output byte_t    data_out,
  output logic     data_oe,
  output word_t    addr_out,
  output logic     addr_oe,
  output flags_t   flags
);

  // --------------------
  // internal buses
  // --------------------

  byte_t  dbus;
  byte_t  reg_byte;
  word_t  reg_pair;
  word_t  mar_q;
  byte_t  acc;
  byte_t  temp;
  byte_t  alu_b;
  byte_t  alu_res;
  flags_t alu_flags;

  // the second operand either comes off the bus this cycle or was parked in TEMP earlier
  assign alu_b = ctrl.alu_b_temp ? temp : dbus;

  z80_regfile regfile_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .ctrl     (ctrl),
    .dbus     (dbus),
    .mar_q    (mar_q),
    .reg_byte (reg_byte),
    .reg_pair (reg_pair)
  );

  // A is always the first operand
  z80_alu alu_i (
    .op    (ctrl.alu_op),
    .a     (acc),
    .b     (alu_b),
    .f_in  (flags),
    .res   (alu_res),
    .f_out (alu_flags)
  );

  z80_acc_flags acc_flags_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .ctrl      (ctrl),
    .dbus      (dbus),
    .alu_res   (alu_res),
    .alu_flags (alu_flags),
    .acc       (acc),
    .flags     (flags),
    .temp      (temp)
  );

  z80_bus_ctrl bus_ctrl_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .ctrl     (ctrl),
    .data_in  (data_in),
    .reg_byte (reg_byte),
    .acc      (acc),
    .flags    (flags),
    .temp     (temp),
    .reg_pair (reg_pair),
    .dbus     (dbus),
    .mar_q    (mar_q),
    .data_out (data_out),
    .data_oe  (data_oe),
    .addr_out (addr_out),
    .addr_oe  (addr_oe)
  );

endmodule

// ==== verif/tb_clock.sv ====
`timescale 1ns/10ps

module tb_clock #(
  parameter int period_ns = 100
) (
  output logic clk
);

  // starts low so the first rising edge comes half a period in
  initial begin
    clk = 1'b0;
    forever begin
      #(period_ns / 2);
      clk = ~clk;
    end
  end

endmodule

// ==== verif/z80_datapath_tb.sv ====
`timescale 1ns/10ps

module z80_datapath_tb import z80_dp_pkg::*; ();

  localparam int clk_period_ns = 100;
  localparam int alu_trials    = 200;
  // five cycles per ALU trial at most, and the directed sections stay under a hundred
  localparam int test_cycles   = 8 + 100 + alu_trials * 5;
  localparam int timeout_ns    = (test_cycles + 20) * clk_period_ns;

  // what the outputs must show late in a checked cycle
  typedef struct packed {
    logic   valid;
    logic   data_oe;
    byte_t  data;
    logic   addr_oe;
    word_t  addr;
    flags_t flags;
  } expect_t;

  typedef struct packed {
    byte_t  res;
    flags_t f;
  } alu_out_t;

  logic     clk;
  logic     rst_n;
  dp_ctrl_t ctrl;
  byte_t    data_in;
  byte_t    data_out;
  logic     data_oe;
  word_t    addr_out;
  logic     addr_oe;
  flags_t   flags;

  // shadow copy of every register in the datapath
  byte_t    m_gpr [6];
  byte_t    m_a;
  byte_t    m_temp;
  flags_t   m_f;
  word_t    m_mar;
  expect_t  expected;
  int       errors;

  tb_clock #(.period_ns(clk_period_ns)) clock_i (.clk(clk));

  z80_datapath z80_datapath_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .ctrl     (ctrl),
    .data_in  (data_in),
    .data_out (data_out),
    .data_oe  (data_oe),
    .addr_out (addr_out),
    .addr_oe  (addr_oe),
    .flags    (flags)
  );

  // --------------------
  // reference model
  // --------------------

  // Z80 flag rules worked out on plain integers
  function automatic alu_out_t alu_ref(alu_op_t op, byte_t a, byte_t b, flags_t f_in);
    alu_out_t r;
    int       cin;
    int       sum;
    int       nib;
    int       sgn;
    int       ones;
    r.res = b;
    r.f   = f_in;
    cin   = 0;
    if ((op == ALU_ADC) || (op == ALU_SBC)) begin
      cin = f_in.bits.c ? 1 : 0;
    end
    case (op)
      ALU_ADD, ALU_ADC: begin
        sum = int'(a) + int'(b) + cin;
        nib = int'(a[3:0]) + int'(b[3:0]) + cin;
        sgn = int'($signed(a)) + int'($signed(b)) + cin;
        r.res       = sum[7:0];
        r.f.bits.c  = (sum > 255);
        r.f.bits.h  = (nib > 15);
        r.f.bits.pv = (sgn > 127) || (sgn < -128);
        r.f.bits.n  = 1'b0;
      end
      ALU_SUB, ALU_SBC: begin
        // a negative difference means a borrow was needed
        sum = int'(a) - int'(b) - cin;
        nib = int'(a[3:0]) - int'(b[3:0]) - cin;
        sgn = int'($signed(a)) - int'($signed(b)) - cin;
        r.res       = sum[7:0];
        r.f.bits.c  = (sum < 0);
        r.f.bits.h  = (nib < 0);
        r.f.bits.pv = (sgn > 127) || (sgn < -128);
        r.f.bits.n  = 1'b1;
      end
      ALU_AND, ALU_OR, ALU_XOR: begin
        if (op == ALU_AND) begin
          r.res = a & b;
        end else if (op == ALU_OR) begin
          r.res = a | b;
        end else begin
          r.res = a ^ b;
        end
        ones = $countones(r.res);
        r.f.bits.pv = ((ones % 2) == 0);
        r.f.bits.h  = (op == ALU_AND);
        r.f.bits.c  = 1'b0;
        r.f.bits.n  = 1'b0;
      end
      default: begin
      end
    endcase
    // PASS_B leaves every flag alone
    if (op != ALU_PASS_B) begin
      r.f.bits.s = r.res[7];
      r.f.bits.z = (r.res == 8'h00);
    end
    return r;
  endfunction

  // value the internal data bus carries under this control word and the model state
  function automatic byte_t bus_value(dp_ctrl_t c, byte_t din);
    case (c.data_src)
      DSRC_REG:  return m_gpr[c.rd_sel];
      DSRC_A:    return m_a;
      DSRC_F:    return m_f.word;
      DSRC_TEMP: return m_temp;
      default:   return din;
    endcase
  endfunction

  function automatic byte_t rand_byte();
    return 8'($urandom);
  endfunction

  // --------------------
  // stimulus and checking
  // --------------------

  task automatic check_value(string name, logic [15:0] got, logic [15:0] exp);
    if (got !== exp) begin
      errors++;
      $display("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      $display("RESULT: FAIL");
      $fatal(1, "output mismatch on %s", name);
    end
  endtask

  // drives one control word on the falling edge and steps the model through the next edge
  task automatic run_cycle(dp_ctrl_t c, byte_t din);
    byte_t      dbus;
    alu_out_t   ar;
    flags_t     nf;
    word_t      old_mar;
    logic [2:0] hi_idx;
    logic [2:0] lo_idx;
    @(negedge clk);
    ctrl    = c;
    data_in = din;
    // every right side below uses the state from before the edge
    dbus    = bus_value(c, din);
    ar      = alu_ref(c.alu_op, m_a, c.alu_b_temp ? m_temp : dbus, m_f);
    old_mar = m_mar;
    hi_idx  = {c.pair_sel, 1'b0};
    lo_idx  = {c.pair_sel, 1'b1};
    case (c.mar_ld)
      MAR_FROM_PAIR:      m_mar = {m_gpr[hi_idx], m_gpr[lo_idx]};
      MAR_LOW_FROM_DATA:  m_mar[7:0] = dbus;
      MAR_HIGH_FROM_DATA: m_mar[15:8] = dbus;
      default:            m_mar = old_mar;
    endcase
    if (c.ld_reg) begin
      m_gpr[c.ld_reg_sel] = dbus;
    end
    // the high byte of a pair is B, D or H
    if (c.ld_pair) begin
      m_gpr[hi_idx] = old_mar[15:8];
      m_gpr[lo_idx] = old_mar[7:0];
    end
    if (c.ld_a) begin
      m_a = c.a_from_alu ? ar.res : dbus;
    end
    if (c.ld_temp) begin
      m_temp = dbus;
    end
    nf = c.ld_f ? ar.f : m_f;
    if (c.carry_cmd == CY_SET) begin
      nf.bits.c = 1'b1;
    end else if (c.carry_cmd == CY_CLEAR) begin
      nf.bits.c = 1'b0;
    end
    m_f = nf;
    // sampled after the edge, so the outputs show the new state under this same word
    expected.valid   = 1'b1;
    expected.data_oe = (c.data_src != DSRC_EXT);
    expected.data    = bus_value(c, din);
    expected.addr_oe = c.addr_drive;
    expected.addr    = m_mar;
    expected.flags   = m_f;
  endtask

  // compare process, one sample a nanosecond before the next falling edge
  always begin
    @(posedge clk);
    #(clk_period_ns / 2 - 1);
    if (expected.valid) begin
      check_value("data_oe", 16'(data_oe), 16'(expected.data_oe));
      if (expected.data_oe) begin
        check_value("data_out", 16'(data_out), 16'(expected.data));
      end
      check_value("addr_oe", 16'(addr_oe), 16'(expected.addr_oe));
      check_value("addr_out", addr_out, expected.addr);
      check_value("flags", 16'(flags.word), 16'(expected.flags.word));
    end
  end

  task automatic read_out(data_src_t src, reg_sel_t sel);
    dp_ctrl_t c;
    c            = '0;
    c.data_src   = src;
    c.rd_sel     = sel;
    c.addr_drive = 1'b1;
    run_cycle(c, 8'h00);
  endtask

  task automatic load_a(byte_t v);
    dp_ctrl_t c;
    c      = '0;
    c.ld_a = 1'b1;
    run_cycle(c, v);
  endtask

  // ALU op on A and data_in with the result and flags written back
  task automatic alu_step(alu_op_t op, carry_cmd_t cy, byte_t b);
    dp_ctrl_t c;
    c            = '0;
    c.ld_a       = 1'b1;
    c.a_from_alu = 1'b1;
    c.ld_f       = 1'b1;
    c.carry_cmd  = cy;
    c.alu_op     = op;
    run_cycle(c, b);
  endtask

  // --------------------
  // test sequences
  // --------------------

  task automatic check_reset_state();
    dp_ctrl_t c;
    c            = '0;
    c.addr_drive = 1'b1;
    // nothing inside drives the pins here
    run_cycle(c, 8'h5a);
    for (int r = 0; r < 6; r++) begin
      read_out(DSRC_REG, reg_sel_t'(3'(r)));
    end
    read_out(DSRC_A, REG_B);
    read_out(DSRC_F, REG_B);
    read_out(DSRC_TEMP, REG_B);
  endtask

  task automatic check_byte_loads();
    dp_ctrl_t c;
    for (int r = 0; r < 6; r++) begin
      c            = '0;
      c.ld_reg     = 1'b1;
      c.ld_reg_sel = reg_sel_t'(3'(r));
      run_cycle(c, rand_byte());
      read_out(DSRC_REG, reg_sel_t'(3'(r)));
    end
    load_a(rand_byte());
    read_out(DSRC_A, REG_B);
    c         = '0;
    c.ld_temp = 1'b1;
    run_cycle(c, rand_byte());
    read_out(DSRC_TEMP, REG_B);
    // a second pass catches a load that spilled into a neighbour
    for (int r = 0; r < 6; r++) begin
      read_out(DSRC_REG, reg_sel_t'(3'(r)));
    end
  endtask

  task automatic check_mar_pairs();
    dp_ctrl_t c;
    for (int p = 0; p < 3; p++) begin
      c        = '0;
      c.mar_ld = MAR_LOW_FROM_DATA;
      run_cycle(c, rand_byte());
      c.mar_ld = MAR_HIGH_FROM_DATA;
      run_cycle(c, rand_byte());
      read_out(DSRC_EXT, REG_B);
      c          = '0;
      c.ld_pair  = 1'b1;
      c.pair_sel = pair_sel_t'(2'(p));
      run_cycle(c, 8'h00);
      read_out(DSRC_REG, reg_sel_t'(3'(2 * p)));
      read_out(DSRC_REG, reg_sel_t'(3'(2 * p + 1)));
    end
    // each pair goes back out through the MAR to the address pins
    for (int p = 0; p < 3; p++) begin
      c            = '0;
      c.mar_ld     = MAR_FROM_PAIR;
      c.pair_sel   = pair_sel_t'(2'(p));
      c.addr_drive = 1'b1;
      run_cycle(c, 8'h00);
    end
  endtask

  task automatic check_alu_ops();
    dp_ctrl_t    c;
    int unsigned kind;
    reg_sel_t    sel;
    for (int t = 0; t < alu_trials; t++) begin
      // operand from 0 a register, 1 TEMP, 2 straight off data_in
      kind = $urandom_range(2);
      sel  = reg_sel_t'(3'($urandom_range(5)));
      load_a(rand_byte());
      c = '0;
      if (kind == 0) begin
        c.ld_reg     = 1'b1;
        c.ld_reg_sel = sel;
        run_cycle(c, rand_byte());
      end else if (kind == 1) begin
        c.ld_temp = 1'b1;
        run_cycle(c, rand_byte());
      end
      c            = '0;
      c.ld_a       = 1'b1;
      c.a_from_alu = 1'b1;
      c.ld_f       = 1'b1;
      c.alu_op     = alu_op_t'(3'($urandom_range(7)));
      if (kind == 0) begin
        c.data_src = DSRC_REG;
        c.rd_sel   = sel;
      end else if (kind == 1) begin
        c.alu_b_temp = 1'b1;
      end
      // with TEMP as the operand the random data_in must be ignored
      run_cycle(c, rand_byte());
      read_out(DSRC_A, REG_B);
      read_out(DSRC_F, REG_B);
    end
  endtask

  task automatic check_carry_override();
    dp_ctrl_t c;
    c           = '0;
    c.carry_cmd = CY_SET;
    run_cycle(c, 8'h00);
    read_out(DSRC_F, REG_B);
    c.carry_cmd = CY_CLEAR;
    run_cycle(c, 8'h00);
    read_out(DSRC_F, REG_B);
    // the carry is known clear now, so this set has to show up in F
    c.carry_cmd = CY_SET;
    run_cycle(c, 8'h00);
    read_out(DSRC_F, REG_B);
    // 01 + 01 leaves no carry, so a set carry can only come from the override
    load_a(8'h01);
    alu_step(ALU_ADD, CY_SET, 8'h01);
    read_out(DSRC_F, REG_B);
    alu_step(ALU_ADC, CY_KEEP, 8'h10);
    read_out(DSRC_A, REG_B);
    // 00 - 01 borrows, and the override wipes it before SBC reads it
    load_a(8'h00);
    alu_step(ALU_SUB, CY_CLEAR, 8'h01);
    read_out(DSRC_F, REG_B);
    alu_step(ALU_SBC, CY_KEEP, 8'h0f);
    read_out(DSRC_A, REG_B);
  endtask

  // --------------------
  // run control
  // --------------------

  initial begin
    void'($urandom(32'hb26495d2));
    errors   = 0;
    rst_n    = 1'b0;
    ctrl     = '0;
    data_in  = '0;
    expected = '0;
    m_gpr    = '{default: '0};
    m_a      = '0;
    m_temp   = '0;
    m_f      = '0;
    m_mar    = '0;
    repeat (8) @(negedge clk);
    rst_n = 1'b1;
    check_reset_state();
    check_byte_loads();
    check_mar_pairs();
    check_alu_ops();
    check_carry_override();
    // let the compare process take its last sample
    repeat (2) @(negedge clk);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  initial begin
    #(timeout_ns);
    $display("RESULT: FAIL");
    $fatal(1, "watchdog expired because the test sequence did not finish in time");
  end

endmodule

// ==== tb.f ====
hw/z80_dp_pkg.sv
hw/z80_regfile.sv
hw/z80_alu.sv
hw/z80_acc_flags.sv
hw/z80_bus_ctrl.sv
hw/z80_datapath.sv
verif/tb_clock.sv
verif/z80_datapath_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f tb.f --top-module z80_datapath_tb -o z80_sim &&
./obj_dir/z80_sim | tee /dev/stderr | grep -q "RESULT: PASS" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
